//--- src/issuePkg.sv
package issuePkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int NUM_WARPS = 4;               // Warps in the core
    localparam int SCB_DEPTH = 4;               // Scoreboard slots per warp
    localparam int REG_W     = 5;               // Architectural register number width
    localparam int SCB_W     = $clog2(SCB_DEPTH);
    localparam int WARP_W    = $clog2(NUM_WARPS);

    typedef logic [REG_W-1:0]  regIdT;
    typedef logic [SCB_W-1:0]  scbIdT;
    typedef logic [WARP_W-1:0] warpIdT;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////

    // One decoded instruction as the issue stage sees it
    typedef struct packed {
        regIdT src1;
        regIdT src2;
        regIdT dst;
        logic  src1Valid;
        logic  src2Valid;
        logic  dstValid;
        logic  replayable;                      // Load or store
        logic  isStore;
    } instrT;

    // Completion event from writeback or branch unit
    typedef struct packed {
        logic   valid;
        warpIdT warp;
        scbIdT  slot;
    } clearT;

    // Memory replay done
    typedef struct packed {
        logic   valid;
        warpIdT warp;
        scbIdT  slot;
        logic   isStore;                        // Store frees its slot right away
    } replayT;

    // Issued instruction with its tags
    typedef struct packed {
        logic   valid;
        warpIdT warp;
        scbIdT  slot;                           // Needed later to free the slot
        instrT  instr;
    } issueT;

endpackage

//--- src/warpScoreboard.sv
`timescale 1ns/1ps

module warpScoreboard #(
    parameter issuePkg::warpIdT warpId = '0    // Warp served by this table
) (
    input  logic              clk,
    input  logic              rst,
    input  issuePkg::instrT   cand,
    input  logic              candValid,
    input  logic              grant,
    input  issuePkg::clearT   wbClear,
    input  issuePkg::clearT   brClear,
    input  issuePkg::replayT  memReplay,
    output logic              ready,
    output issuePkg::scbIdT   freeSlot,
    output logic              empty,
    output logic              full
);

    ////////////////////////////////////////
    // Slot state
    ////////////////////////////////////////

    issuePkg::instrT                    entryQ [issuePkg::SCB_DEPTH];  // Instruction per slot
    logic [issuePkg::SCB_DEPTH-1:0]     validQ;
    logic [issuePkg::SCB_DEPTH-1:0]     completeQ;  // Low while load/store awaits replay

    logic                               wbHit;
    logic                               brHit;
    logic                               rpHit;
    logic [issuePkg::SCB_DEPTH-1:0]     validCleared;
    logic [issuePkg::SCB_DEPTH-1:0]     hazardVec;
    logic                               hazard;

    // Events tagged for another warp are ignored
    assign wbHit = wbClear.valid && (wbClear.warp == warpId);
    assign brHit = brClear.valid && (brClear.warp == warpId);
    assign rpHit = memReplay.valid && (memReplay.warp == warpId);

    ////////////////////////////////////////
    // Clear bypass
    ////////////////////////////////////////

    // Slots freed this cycle already count as free
    always_comb begin
        validCleared = validQ;
        if (rpHit && memReplay.isStore) begin
            validCleared[memReplay.slot] = 1'b0;        // Store done at replay
        end
        // Load must have seen its replay in an earlier cycle
        if (wbHit && completeQ[wbClear.slot]) begin
            validCleared[wbClear.slot] = 1'b0;
        end
        if (brHit) begin
            validCleared[brClear.slot] = 1'b0;          // Branch frees unconditionally
        end
    end

    assign full  = &validCleared;
    assign empty = ~|validCleared;

    // Lowest free slot, scan from the top so the smallest index wins
    always_comb begin
        freeSlot = '0;
        for (int i = issuePkg::SCB_DEPTH - 1; i >= 0; i--) begin
            if (!validCleared[i]) begin
                freeSlot = issuePkg::scbIdT'(i);
            end
        end
    end

    ////////////////////////////////////////
    // Hazard check
    ////////////////////////////////////////

    always_comb begin
        logic raw;
        logic waw;
        logic war;
        for (int i = 0; i < issuePkg::SCB_DEPTH; i++) begin
            // Reads after an older write
            raw = (cand.src1Valid && entryQ[i].dstValid && (cand.src1 == entryQ[i].dst))
                || (cand.src2Valid && entryQ[i].dstValid && (cand.src2 == entryQ[i].dst));
            // Two writes to one register
            waw = cand.dstValid && entryQ[i].dstValid && (cand.dst == entryQ[i].dst);
            // Write over a register an older instruction still reads
            war = (cand.dstValid && entryQ[i].src1Valid && (cand.dst == entryQ[i].src1))
                || (cand.dstValid && entryQ[i].src2Valid && (cand.dst == entryQ[i].src2));
            hazardVec[i] = (raw || waw || war) && validCleared[i];
        end
    end

    assign hazard = |hazardVec;
    assign ready  = candValid && !hazard && !full;

    ////////////////////////////////////////
    // Allocation
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            validQ    <= '0;
            completeQ <= '1;
        end else begin
            validQ <= validCleared;
            if (rpHit) begin
                completeQ[memReplay.slot] <= 1'b1;
            end
            // Grant comes last, it owns the slot it writes
            if (grant) begin
                validQ[freeSlot]    <= 1'b1;
                completeQ[freeSlot] <= !cand.replayable;
            end
        end
    end

    // Payload only, the valid bit guards it
    always_ff @(posedge clk) begin
        if (grant) begin
            entryQ[freeSlot] <= cand;
        end
    end

endmodule

//--- src/issueArbiter.sv
`timescale 1ns/1ps

module issueArbiter (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [issuePkg::NUM_WARPS-1:0]  ready,
    input  logic                            issueReady,
    output logic [issuePkg::NUM_WARPS-1:0]  grant
);

    ////////////////////////////////////////
    // Round-robin choice
    ////////////////////////////////////////

    issuePkg::warpIdT   lastPtr;        // Warp granted most recently
    issuePkg::warpIdT   winner;
    logic               found;

    // Search starts just past the last winner
    always_comb begin
        int idx;
        winner = lastPtr;
        found  = 1'b0;
        for (int i = 1; i <= issuePkg::NUM_WARPS; i++) begin
            idx = (int'(lastPtr) + i) % issuePkg::NUM_WARPS;
            if (!found && ready[idx]) begin
                winner = issuePkg::warpIdT'(idx);
                found  = 1'b1;
            end
        end
    end

    // Nothing goes out under back-pressure
    always_comb begin
        grant = '0;
        if (found && issueReady) begin
            grant[winner] = 1'b1;
        end
    end

    ////////////////////////////////////////
    // Pointer
    ////////////////////////////////////////

    // Reset value 0, so warp 1 is first in line
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lastPtr <= '0;
        end else if (found && issueReady) begin
            lastPtr <= winner;          // Only moves on a real grant
        end
    end

endmodule

//--- src/issueRegister.sv
`timescale 1ns/1ps

module issueRegister (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [issuePkg::NUM_WARPS-1:0]                  grant,
    input  issuePkg::instrT [issuePkg::NUM_WARPS-1:0]       cand,
    input  issuePkg::scbIdT [issuePkg::NUM_WARPS-1:0]       freeSlot,
    output issuePkg::issueT                                 issueOut
);

    issuePkg::warpIdT   grantIdx;
    logic               anyGrant;
    logic               validQ;
    issuePkg::warpIdT   warpQ;
    issuePkg::scbIdT    slotQ;
    issuePkg::instrT    instrQ;

    // One-hot to index
    always_comb begin
        grantIdx = '0;
        for (int i = 0; i < issuePkg::NUM_WARPS; i++) begin
            if (grant[i]) begin
                grantIdx = issuePkg::warpIdT'(i);
            end
        end
    end

    assign anyGrant = |grant;

    ////////////////////////////////////////
    // Output stage
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            validQ <= 1'b0;
        end else begin
            validQ <= anyGrant;         // High for one cycle per grant
        end
    end

    always_ff @(posedge clk) begin
        if (anyGrant) begin
            warpQ  <= grantIdx;
            slotQ  <= freeSlot[grantIdx];   // Slot just allocated in that warp
            instrQ <= cand[grantIdx];
        end
    end

    assign issueOut = '{valid: validQ, warp: warpQ, slot: slotQ, instr: instrQ};

endmodule

//--- src/warpIssueStage.sv
`timescale 1ns/1ps

module warpIssueStage (
    input  logic                                            clk,
    input  logic                                            rst,

    // Candidates, one per warp
    input  logic [issuePkg::NUM_WARPS-1:0]                  candValid,
    input  issuePkg::instrT [issuePkg::NUM_WARPS-1:0]       cand,
    input  logic                                            issueReady,

    // Completion events
    input  issuePkg::clearT                                 wbClear,
    input  issuePkg::clearT                                 brClear,
    input  issuePkg::replayT                                memReplay,

    output logic [issuePkg::NUM_WARPS-1:0]                  candTaken,  // Same as grant
    output issuePkg::issueT                                 issueOut,
    output logic [issuePkg::NUM_WARPS-1:0]                  warpEmpty,
    output logic [issuePkg::NUM_WARPS-1:0]                  warpFull
);

    ////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////

    logic [issuePkg::NUM_WARPS-1:0]             readyVec;   // Warp may issue now
    issuePkg::scbIdT [issuePkg::NUM_WARPS-1:0]  freeSlotVec;

    ////////////////////////////////////////
    // Per-warp scoreboards
    ////////////////////////////////////////

    // All clears fan out, each table filters on its own warp tag
    for (genvar w = 0; w < issuePkg::NUM_WARPS; w++) begin : genScb
        warpScoreboard #(
            .warpId     (issuePkg::warpIdT'(w))
        ) scb (
            .clk        (clk),
            .rst        (rst),
            .cand       (cand[w]),
            .candValid  (candValid[w]),
            .grant      (candTaken[w]),     // Allocates at this edge
            .wbClear    (wbClear),
            .brClear    (brClear),
            .memReplay  (memReplay),
            .ready      (readyVec[w]),
            .freeSlot   (freeSlotVec[w]),
            .empty      (warpEmpty[w]),
            .full       (warpFull[w])
        );
    end

    ////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////

    // Grant doubles as the taken pulse back to each warp
    issueArbiter arb (
        .clk        (clk),
        .rst        (rst),
        .ready      (readyVec),
        .issueReady (issueReady),
        .grant      (candTaken)
    );

    ////////////////////////////////////////
    // Issue register
    ////////////////////////////////////////

    // Captures candidate and slot in the grant cycle
    issueRegister outReg (
        .clk        (clk),
        .rst        (rst),
        .grant      (candTaken),
        .cand       (cand),
        .freeSlot   (freeSlotVec),
        .issueOut   (issueOut)
    );

endmodule

//--- verif/tbWarpIssue.sv
`timescale 1ns/1ps

module tbWarpIssue;

    ////////////////////////////////////////
    // DUT signals
    ////////////////////////////////////////

    logic                                       clk = 1'b0;
    logic                                       rst;
    logic [issuePkg::NUM_WARPS-1:0]             candValid;
    issuePkg::instrT [issuePkg::NUM_WARPS-1:0]  cand;
    logic                                       issueReady;
    issuePkg::clearT                            wbClear;
    issuePkg::clearT                            brClear;
    issuePkg::replayT                           memReplay;
    logic [issuePkg::NUM_WARPS-1:0]             candTaken;
    issuePkg::issueT                            issueOut;
    logic [issuePkg::NUM_WARPS-1:0]             warpEmpty;
    logic [issuePkg::NUM_WARPS-1:0]             warpFull;

    // Model's view of one warp after this cycle's clears
    typedef struct packed {
        logic [issuePkg::SCB_DEPTH-1:0] validAfter;
        logic                           hazard;
        logic                           full;
        logic                           empty;
        issuePkg::scbIdT                freeSlot;
    } viewT;

    // Reference slot tables
    issuePkg::instrT                mEntry [issuePkg::NUM_WARPS][issuePkg::SCB_DEPTH];
    logic [issuePkg::SCB_DEPTH-1:0] mValid [issuePkg::NUM_WARPS];
    logic [issuePkg::SCB_DEPTH-1:0] mComplete [issuePkg::NUM_WARPS];
    issuePkg::warpIdT               mPtr;               // Last granted warp

    logic                           pendValid;          // Grant seen one cycle ago
    issuePkg::issueT                pendIssue;
    logic [issuePkg::NUM_WARPS-1:0] lastTaken;          // candTaken of the last cycle
    logic [31:0]                    lfsrState;
    int                             errors = 0;
    int                             cycleCount = 0;

    // Stimulus modes
    logic                           genOn;
    logic                           denseGen;           // Candidate every free cycle
    logic                           indepMode;          // No register operands
    logic                           clearsOn;
    logic                           bpMode;             // Random back-pressure
    logic                           issueHigh;
    logic [issuePkg::NUM_WARPS-1:0] warpOn;

    warpIssueStage dut0 (
        .clk        (clk),
        .rst        (rst),
        .candValid  (candValid),
        .cand       (cand),
        .issueReady (issueReady),
        .wbClear    (wbClear),
        .brClear    (brClear),
        .memReplay  (memReplay),
        .candTaken  (candTaken),
        .issueOut   (issueOut),
        .warpEmpty  (warpEmpty),
        .warpFull   (warpFull)
    );

    initial begin
        forever #10 clk = ~clk;                         // 20 ns period
    end

    ////////////////////////////////////////
    // Random source
    ////////////////////////////////////////

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] takeBits(int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
        end
        return bits;
    endfunction

    function automatic issuePkg::instrT makeInstr(logic noOperands);
        issuePkg::instrT i;
        i.src1       = issuePkg::regIdT'(takeBits(3));  // Registers 0..7 so hazards are common
        i.src2       = issuePkg::regIdT'(takeBits(3));
        i.dst        = issuePkg::regIdT'(takeBits(3));
        i.src1Valid  = noOperands ? 1'b0 : 1'(takeBits(1));
        i.src2Valid  = noOperands ? 1'b0 : 1'(takeBits(1));
        i.dstValid   = noOperands ? 1'b0 : 1'(takeBits(1));
        i.replayable = (takeBits(2) == 0);              // About one in four is memory
        i.isStore    = i.replayable && takeBits(1);
        return i;
    endfunction

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic sameReg(logic aValid, issuePkg::regIdT a,
                                     logic bValid, issuePkg::regIdT b);
        return aValid && bValid && (a == b);
    endfunction

    // Hazard, full, empty and lowest free slot with clears bypassed
    function automatic viewT predictWarp(int w);
        viewT            v;
        issuePkg::instrT c;
        issuePkg::instrT e;
        logic            raw;
        logic            waw;
        logic            war;
        logic            gotFree;
        c = cand[w];
        v.validAfter = mValid[w];
        if (memReplay.valid && memReplay.warp == w && memReplay.isStore) begin
            v.validAfter[memReplay.slot] = 1'b0;
        end
        if (wbClear.valid && wbClear.warp == w && mComplete[w][wbClear.slot]) begin
            v.validAfter[wbClear.slot] = 1'b0;          // Incomplete load stays
        end
        if (brClear.valid && brClear.warp == w) begin
            v.validAfter[brClear.slot] = 1'b0;
        end
        v.hazard   = 1'b0;
        v.freeSlot = '0;
        gotFree    = 1'b0;
        for (int s = 0; s < issuePkg::SCB_DEPTH; s++) begin
            if (v.validAfter[s]) begin
                e   = mEntry[w][s];
                raw = sameReg(c.src1Valid, c.src1, e.dstValid, e.dst)
                    || sameReg(c.src2Valid, c.src2, e.dstValid, e.dst);
                waw = sameReg(c.dstValid, c.dst, e.dstValid, e.dst);
                war = sameReg(c.dstValid, c.dst, e.src1Valid, e.src1)
                    || sameReg(c.dstValid, c.dst, e.src2Valid, e.src2);
                if (raw || waw || war) v.hazard = 1'b1;
            end else if (!gotFree) begin
                v.freeSlot = issuePkg::scbIdT'(s);
                gotFree    = 1'b1;
            end
        end
        v.full  = &v.validAfter;
        v.empty = ~|v.validAfter;
        return v;
    endfunction

    // First ready warp after the pointer
    function automatic logic [issuePkg::NUM_WARPS-1:0] pickGrant(
            logic [issuePkg::NUM_WARPS-1:0] r, issuePkg::warpIdT ptr);
        logic [issuePkg::NUM_WARPS-1:0] g;
        int                             idx;
        g = '0;
        for (int k = 1; k <= issuePkg::NUM_WARPS; k++) begin
            idx = (int'(ptr) + k) % issuePkg::NUM_WARPS;
            if (g == '0 && r[idx]) g[idx] = 1'b1;
        end
        return g;
    endfunction

    function automatic logic modelEmpty();
        logic e;
        e = 1'b1;
        for (int w = 0; w < issuePkg::NUM_WARPS; w++) begin
            if (mValid[w] != '0) e = 1'b0;
        end
        return e;
    endfunction

    ////////////////////////////////////////
    // Comparing process
    ////////////////////////////////////////

    // Mid-cycle when inputs and DUT outputs have settled
    always @(negedge clk) begin
        viewT                           view [issuePkg::NUM_WARPS];
        logic [issuePkg::NUM_WARPS-1:0] readyExp;
        logic [issuePkg::NUM_WARPS-1:0] emptyExp;
        logic [issuePkg::NUM_WARPS-1:0] fullExp;
        logic [issuePkg::NUM_WARPS-1:0] expGrant;
        int                             gw;
        gw = 0;
        for (int w = 0; w < issuePkg::NUM_WARPS; w++) begin
            view[w]     = predictWarp(w);
            readyExp[w] = candValid[w] && !view[w].hazard && !view[w].full;
            emptyExp[w] = view[w].empty;
            fullExp[w]  = view[w].full;
        end
        expGrant = issueReady ? pickGrant(readyExp, mPtr) : '0;
        assert (candTaken === expGrant) else begin
            errors++;
            $display("FAILED candTaken expected %h got %h", expGrant, candTaken);
        end
        assert (warpEmpty === emptyExp) else begin
            errors++;
            $display("FAILED warpEmpty expected %h got %h", emptyExp, warpEmpty);
        end
        assert (warpFull === fullExp) else begin
            errors++;
            $display("FAILED warpFull expected %h got %h", fullExp, warpFull);
        end
        if (pendValid) begin
            assert (issueOut === pendIssue) else begin
                errors++;
                $display("FAILED issueOut expected %h got %h", pendIssue, issueOut);
            end
        end else begin
            assert (issueOut.valid === 1'b0) else begin
                errors++;
                $display("FAILED issueOut.valid expected 0 got %h", issueOut.valid);
            end
        end
        lastTaken = candTaken;
        if (rst) begin
            for (int w = 0; w < issuePkg::NUM_WARPS; w++) begin
                if (expGrant[w]) gw = w;
                mValid[w] = view[w].validAfter;
                if (memReplay.valid && memReplay.warp == w) begin
                    mComplete[w][memReplay.slot] = 1'b1;
                end
                if (expGrant[w]) begin                  // Allocate at the coming edge
                    mValid[w][view[w].freeSlot]    = 1'b1;
                    mComplete[w][view[w].freeSlot] = !cand[w].replayable;
                    mEntry[w][view[w].freeSlot]    = cand[w];
                end
            end
            pendValid = |expGrant;
            pendIssue = '{valid: 1'b1, warp: issuePkg::warpIdT'(gw),
                          slot: view[gw].freeSlot, instr: cand[gw]};
            if (|expGrant) mPtr = issuePkg::warpIdT'(gw);
        end
    end

    // Phases total about 1500 cycles and 4000 leaves ample margin
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= 4000) begin
            $display("Run stopped at cycle %0d, a phase never finished", cycleCount);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // Random valid slot, or one still waiting for replay
    task automatic findSlot(input logic wantPending, output logic hit,
                            output issuePkg::warpIdT fw, output issuePkg::scbIdT fs);
        int startW;
        int startS;
        int w;
        int s;
        hit    = 1'b0;
        fw     = '0;
        fs     = '0;
        startW = takeBits(2);
        startS = takeBits(2);
        for (int k = 0; k < issuePkg::NUM_WARPS * issuePkg::SCB_DEPTH; k++) begin
            w = (startW + k / issuePkg::SCB_DEPTH) % issuePkg::NUM_WARPS;
            s = (startS + k) % issuePkg::SCB_DEPTH;
            if (!hit && mValid[w][s] && (!wantPending || !mComplete[w][s])) begin
                hit = 1'b1;
                fw  = issuePkg::warpIdT'(w);
                fs  = issuePkg::scbIdT'(s);
            end
        end
    endtask

    task automatic driveClears();
        logic             hit;
        issuePkg::warpIdT fw;
        issuePkg::scbIdT  fs;
        wbClear   = '0;
        brClear   = '0;
        memReplay = '0;
        if (clearsOn) begin
            if (takeBits(1)) begin                      // May hit an incomplete load
                findSlot(1'b0, hit, fw, fs);
                if (hit) wbClear = '{valid: 1'b1, warp: fw, slot: fs};
            end
            if (takeBits(3) == 0) begin                 // Branch clears are rarer
                findSlot(1'b0, hit, fw, fs);
                if (hit) brClear = '{valid: 1'b1, warp: fw, slot: fs};
            end
            if (takeBits(1)) begin
                findSlot(1'b1, hit, fw, fs);
                if (hit) begin
                    memReplay = '{valid: 1'b1, warp: fw, slot: fs,
                                  isStore: mEntry[fw][fs].isStore};
                end
            end
        end
    endtask

    // One cycle of input changes 2 ns after the edge
    task automatic stepCycle();
        @(posedge clk);
        #2;
        for (int w = 0; w < issuePkg::NUM_WARPS; w++) begin
            if (lastTaken[w]) candValid[w] = 1'b0;      // Consumed at that edge
            if (!candValid[w] && genOn && warpOn[w] && (denseGen || takeBits(1))) begin
                cand[w]      = makeInstr(indepMode);
                candValid[w] = 1'b1;
            end
        end
        issueReady = bpMode ? (takeBits(2) != 0) : issueHigh;
        driveClears();
    endtask

    task automatic runCycles(int n);
        repeat (n) stepCycle();
    endtask

    // Stop new candidates and keep clearing until no slot or candidate is left
    task automatic drainAll();
        genOn = 1'b0;
        while (!(modelEmpty() && candValid == '0)) begin
            stepCycle();
        end
    endtask

    initial begin
        lfsrState  = 32'hda6fb1c2;
        rst        = 1'b0;
        candValid  = '0;
        cand       = '0;
        issueReady = 1'b0;
        wbClear    = '0;
        brClear    = '0;
        memReplay  = '0;
        genOn      = 1'b0;
        denseGen   = 1'b0;
        indepMode  = 1'b1;
        clearsOn   = 1'b0;
        bpMode     = 1'b0;
        issueHigh  = 1'b1;
        warpOn     = '1;
        for (int w = 0; w < issuePkg::NUM_WARPS; w++) begin
            mValid[w]    = '0;
            mComplete[w] = '1;
        end
        mPtr      = '0;
        pendValid = 1'b0;
        lastTaken = '0;
        repeat (5) @(posedge clk);
        #2 rst = 1'b1;

        // Independent instructions take the lowest slot and issue one cycle later
        genOn    = 1'b1;
        clearsOn = 1'b1;
        runCycles(200);

        // Operand hazards plus loads and stores
        indepMode = 1'b0;
        runCycles(500);
        drainAll();

        // Warp 0 alone with no clears fills up
        genOn     = 1'b1;
        indepMode = 1'b1;
        clearsOn  = 1'b0;
        denseGen  = 1'b1;
        warpOn    = 4'b0001;
        runCycles(20);
        @(negedge clk);
        #1;
        assert (warpFull[0] === 1'b1) else begin
            errors++;
            $display("FAILED warpFull expected 1 got %h", warpFull[0]);
        end
        warpOn = 4'b1110;                               // Others keep going
        runCycles(25);

        // Back-pressure as a solid stretch then random
        warpOn    = '1;
        denseGen  = 1'b0;
        indepMode = 1'b0;
        clearsOn  = 1'b1;
        issueHigh = 1'b0;
        runCycles(20);
        issueHigh = 1'b1;
        bpMode    = 1'b1;
        runCycles(300);

        // Drain everything
        bpMode = 1'b0;
        drainAll();
        clearsOn = 1'b0;
        runCycles(3);
        @(negedge clk);
        #1;
        assert (warpEmpty === '1) else begin
            errors++;
            $display("FAILED warpEmpty expected %h got %h", 4'hf, warpEmpty);
        end

        $display("Run complete after %0d cycles, %0d errors", cycleCount, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
src/issuePkg.sv
src/warpScoreboard.sv
src/issueArbiter.sv
src/issueRegister.sv
src/warpIssueStage.sv
verif/tbWarpIssue.sv

//--- Bender.yml
package:
  name: warpIssue

sources:
  # Package first, then leaf modules and the top level
  - src/issuePkg.sv
  - src/warpScoreboard.sv
  - src/issueArbiter.sv
  - src/issueRegister.sv
  - src/warpIssueStage.sv

  # Testbench
  - target: test
    files:
      - verif/tbWarpIssue.sv
